// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= audio_board.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== audio_board.f ====
hw/board_pkg.sv
hw/slow_clk_gen.sv
hw/inmp441_mic_i2s_receiver.sv
hw/i2s_audio_out.sv
hw/seven_segment_display.sv
hw/lab_top.sv
hw/board_specific_top.sv
sim/tb_board_top.sv

// ==== hw/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // Microphone I2S timing, in clk cycles and sck cycles
    localparam int mic_sck_div       = 8;     // Half period of sck
    localparam int mic_bits_per_slot = 32;

    localparam int w_sample = 24;
    localparam int w_sound  = 16;

    // Audio DAC side
    localparam int aud_bclk_div = 8;
    localparam int aud_mclk_div = 2;

    //------------------------------------------------
    // Active-high abcdefgh, segment a in bit 7, dot off

    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;  // Lower case b
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;  // Lower case d
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== hw/board_specific_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_specific_top import board_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1,
    parameter int w_key       = 2,
    parameter int w_sw        = 10,
    parameter int w_led       = 10,
    parameter int w_digit     = 6,
    parameter int w_gpio      = 36
)
(
    input  logic                clk,
    input  logic [w_key - 1:0]  key,
    input  logic [w_sw - 1:0]   sw,
    output logic [w_led - 1:0]  led,
    output logic [7:0]          hex0,
    output logic [7:0]          hex1,
    output logic [7:0]          hex2,
    output logic [7:0]          hex3,
    output logic [7:0]          hex4,
    output logic [7:0]          hex5,
    inout  wire  [w_gpio - 1:0] gpio
);

    localparam int w_lab_sw = w_sw - 1;    // Top switch is the reset

    logic                  rst;
    logic [w_lab_sw - 1:0] lab_sw;
    logic [w_key - 1:0]    lab_key;
    logic                  slow_clk;
    logic [w_sample - 1:0] mic;
    logic                  mic_valid;
    logic [w_sound - 1:0]  sound;
    logic [7:0]            abcdefgh;
    logic [7:0]            hgfedcba;
    logic [w_digit - 1:0]  digit;

    assign rst     = sw[w_sw - 1];
    assign lab_sw  = sw[w_lab_sw - 1:0];
    assign lab_key = ~key;                  // Keys pull low when pressed

    //------------------------------------------------

    slow_clk_gen #(.clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz)) i_slow_clk_gen
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .slow_clk ( slow_clk )
    );

    lab_top
    #(
        .clk_mhz ( clk_mhz  ),
        .w_key   ( w_key    ),
        .w_sw    ( w_lab_sw ),
        .w_led   ( w_led    ),
        .w_digit ( w_digit  )
    )
    i_lab_top
    (
        .clk       ( clk       ),
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),
        .key       ( lab_key   ),
        .sw        ( lab_sw    ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid ),
        .led       ( led       ),
        .abcdefgh  ( abcdefgh  ),
        .digit     ( digit     ),
        .sound     ( sound     )
    );

    //------------------------------------------------
    // Static HEX displays from the scanned bus

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            {hex0, hex1, hex2, hex3, hex4, hex5} <= '1;
        else
        begin
            if (digit[0]) hex0 <= ~hgfedcba;   // Segments lit low
            if (digit[1]) hex1 <= ~hgfedcba;
            if (digit[2]) hex2 <= ~hgfedcba;
            if (digit[3]) hex3 <= ~hgfedcba;
            if (digit[4]) hex4 <= ~hgfedcba;
            if (digit[5]) hex5 <= ~hgfedcba;
        end
    end

    //------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .sd          ( gpio[5]   ),
        .lr          ( gpio[0]   ),
        .ws          ( gpio[2]   ),
        .sck         ( gpio[4]   ),
        .value       ( mic       ),
        .value_valid ( mic_valid )
    );

    assign gpio[1] = 1'b0;      // Mic ground
    assign gpio[3] = 1'b1;      // Mic supply

    i2s_audio_out #(.clk_mhz(clk_mhz)) i_audio_out
    (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .data_in ( sound    ),
        .mclk    ( gpio[33] ),
        .bclk    ( gpio[31] ),
        .lrclk   ( gpio[27] ),
        .sdata   ( gpio[29] )
    );

    a_digit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot(digit));

endmodule

`default_nettype wire

// ==== hw/i2s_audio_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_audio_out import board_pkg::*;
#(
    parameter int clk_mhz = 50
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_sound - 1:0] data_in,
    output logic                 mclk,
    output logic                 bclk,
    output logic                 lrclk,
    output logic                 sdata
);

    localparam int w_mclk_cnt = aud_mclk_div > 1 ? $clog2(aud_mclk_div) : 1;
    localparam int w_bclk_cnt = aud_bclk_div > 1 ? $clog2(aud_bclk_div) : 1;
    localparam int w_frame    = $clog2(2 * w_sound);   // Bclk cycles per frame
    localparam int w_idx      = $clog2(w_sound);

    // Resulting audio frame rate
    localparam int frame_hz = clk_mhz * 1_000_000 / (4 * aud_bclk_div * w_sound);

    logic [w_mclk_cnt - 1:0] mclk_cnt;
    logic [w_bclk_cnt - 1:0] bclk_cnt;
    logic [w_frame - 1:0]    bit_cnt;
    logic [w_frame - 1:0]    nxt_bit;
    logic [w_idx - 1:0]      bit_idx;
    logic [w_sound - 1:0]    word;
    logic                    bclk_fall;

    //------------------------------------------------
    // Clock dividers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk_cnt <= '0;
            mclk     <= 1'b0;
        end
        else if (mclk_cnt == w_mclk_cnt'(aud_mclk_div - 1))
        begin
            mclk_cnt <= '0;
            mclk     <= ~mclk;
        end
        else
            mclk_cnt <= mclk_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bclk_cnt <= '0;
            bclk     <= 1'b0;
        end
        else if (bclk_cnt == w_bclk_cnt'(aud_bclk_div - 1))
        begin
            bclk_cnt <= '0;
            bclk     <= ~bclk;
        end
        else
            bclk_cnt <= bclk_cnt + 1'b1;
    end

    assign bclk_fall = bclk && (bclk_cnt == w_bclk_cnt'(aud_bclk_div - 1));

    //------------------------------------------------
    // Frame counter and serializer

    assign nxt_bit = bit_cnt + 1'b1;
    // Slot position 1 carries the MSB, position 0 the LSB of the half before
    assign bit_idx = w_idx'(0) - nxt_bit[w_idx - 1:0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt <= '1;      // First falling bclk starts a frame
            lrclk   <= 1'b0;
            sdata   <= 1'b0;
            word    <= '0;
        end
        else if (bclk_fall)
        begin
            bit_cnt <= nxt_bit;
            lrclk   <= nxt_bit[w_frame - 1];
            sdata   <= word[bit_idx];
            if (nxt_bit == '0)
                word <= data_in;    // Same word in both halves
        end
    end

    a_frame_rate: assert property (@(posedge clk) disable iff (rst)
        frame_hz >= 8000);

    a_lrclk_on_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(lrclk) |-> $fell(bclk));

endmodule

`default_nettype wire

// ==== hw/inmp441_mic_i2s_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module inmp441_mic_i2s_receiver import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  sd,
    output logic                  lr,
    output logic                  ws,
    output logic                  sck,
    output logic [w_sample - 1:0] value,
    output logic                  value_valid
);

    localparam int w_div = mic_sck_div > 1 ? $clog2(mic_sck_div) : 1;
    localparam int w_bit = $clog2(mic_bits_per_slot);

    logic [w_div - 1:0]    div_cnt;
    logic [w_bit - 1:0]    bit_cnt;
    logic [w_sample - 1:0] shreg;
    logic                  sck_edge;
    logic                  sck_rise;
    logic                  sck_fall;
    logic                  lsb_rise;

    assign lr = 1'b0;   // Mic answers in the left slot

    assign sck_edge = (div_cnt == w_div'(mic_sck_div - 1));
    assign sck_rise = sck_edge && !sck;
    assign sck_fall = sck_edge && sck;

    // Rising sck that carries the sample LSB, one delay bit plus 24 data bits
    assign lsb_rise = sck_rise && !ws && (bit_cnt == w_bit'(w_sample));

    //------------------------------------------------
    // Bit clock and word select

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end
        else if (sck_fall)
        begin
            if (bit_cnt == w_bit'(mic_bits_per_slot - 1))
            begin
                bit_cnt <= '0;
                ws      <= ~ws;   // Slot boundary on falling sck
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //------------------------------------------------
    // Data capture, MSB first

    always_ff @(posedge clk)
    begin
        if (sck_rise && !ws)
            shreg <= {shreg[w_sample - 2:0], sd};
        if (lsb_rise)
            value <= {shreg[w_sample - 2:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            value_valid <= 1'b0;
        else
            value_valid <= lsb_rise;
    end

    a_valid_single: assert property (@(posedge clk) disable iff (rst)
        value_valid |=> !value_valid);

endmodule

`default_nettype wire

// ==== hw/lab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_top import board_pkg::*;
#(
    parameter int clk_mhz = 50,
    parameter int w_key   = 2,
    parameter int w_sw    = 9,
    parameter int w_led   = 10,
    parameter int w_digit = 6
)
(
    input  logic                  clk,
    input  logic                  slow_clk,
    input  logic                  rst,
    input  logic [w_key - 1:0]    key,
    input  logic [w_sw - 1:0]     sw,
    input  logic [w_sample - 1:0] mic,
    input  logic                  mic_valid,
    output logic [w_led - 1:0]    led,
    output logic [7:0]            abcdefgh,
    output logic [w_digit - 1:0]  digit,
    output logic [w_sound - 1:0]  sound
);

    // Mic sample rate at this clock
    localparam int mic_rate_hz =
        clk_mhz * 1_000_000 / (4 * mic_sck_div * mic_bits_per_slot);

    logic [w_sample - 1:0] sample;
    logic                  shown;      // A sample has been loaded
    logic [7:0]            seg_code;
    logic                  hold;
    logic                  mute;

    assign hold = key[0];
    assign mute = sw[0];

    //------------------------------------------------
    // Sample hold and sound

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample <= '0;
            shown  <= 1'b0;
        end
        else if (mic_valid && !hold)
        begin
            sample <= mic;      // Dropped while held
            shown  <= 1'b1;
        end
    end

    assign sound = mute ? '0 : sample[w_sample - 1 -: w_sound];

    // LED counter
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            led <= '0;
        else if (slow_clk)
            led <= led + 1'b1;
    end

    //------------------------------------------------

    seven_segment_display #(.w_digit(w_digit)) i_display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( sample   ),
        .abcdefgh ( seg_code ),
        .digit    ( digit    )
    );

    assign abcdefgh = shown ? seg_code : 8'h00;   // Dark until first sample

    a_mic_rate: assert property (@(posedge clk) disable iff (rst)
        mic_rate_hz >= 8000);

endmodule

`default_nettype wire

// ==== hw/seven_segment_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module seven_segment_display import board_pkg::*;
#(
    parameter int w_digit = 6
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [w_sample - 1:0] number,
    output logic [7:0]            abcdefgh,
    output logic [w_digit - 1:0]  digit
);

    localparam int n_nibbles = w_sample / 4;

    logic [3:0]           dwell;
    logic [w_digit - 1:0] nxt_digit;
    logic [3:0]           nibble;

    // Next one-hot select, rotates after 16 cycles
    always_comb
    begin
        if (dwell == 4'hf)
            nxt_digit = {digit[w_digit - 2:0], digit[w_digit - 1]};
        else
            nxt_digit = digit;
    end

    // Nibble for the digit that will be lit
    always_comb
    begin
        nibble = 4'h0;
        for (int i = 0; i < w_digit && i < n_nibbles; i++)
        begin
            if (nxt_digit[i])
                nibble = number[i * 4 +: 4];
        end
    end

    //------------------------------------------------
    // Code and select change in the same cycle

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dwell    <= '0;
            digit    <= w_digit'(1);
            abcdefgh <= '0;
        end
        else
        begin
            dwell    <= dwell + 1'b1;
            digit    <= nxt_digit;
            abcdefgh <= hex_to_segments(nibble);
        end
    end

endmodule

`default_nettype wire

// ==== hw/slow_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module slow_clk_gen
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    // Fast clock cycles between two strobes
    localparam int period = clk_mhz * 1_000_000 / slow_clk_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt      <= w_cnt'(period - 1);
            slow_clk <= 1'b0;
        end
        else
        begin
            slow_clk <= (cnt == '0);      // One cycle wide
            if (cnt == '0)
                cnt <= w_cnt'(period - 1);
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== sim/board_stim.mem ====
// Board testbench stimulus, one step per line
// Columns: mic sample in bits 31..8, mute in bit 4, hold in bit 0; ffffffff ends the table
12345600
89abcdef
fedcba00
00000000
a5c3e110
3c5a9610
0f1e2d00
77665501
deadbe01
deadbe11
c0ffee00
80000100
7fffff00
ffffff00
ffffffff

// ==== sim/tb_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_board_top import board_pkg::*; ();

    localparam int clk_mhz       = 100;
    localparam int slow_clk_hz   = 500_000;    // One strobe per 200 clk
    localparam int slow_period   = 200;
    localparam int w_key         = 2;
    localparam int w_sw          = 10;
    localparam int w_led         = 10;
    localparam int w_digit       = 6;
    localparam int w_gpio        = 36;
    localparam int max_steps     = 64;
    localparam int settle_clk    = 120;
    localparam int mic_frame_clk = 4 * mic_sck_div * mic_bits_per_slot;

    logic                clk = 1'b0;
    logic [w_key - 1:0]  key = '1;                             // No key pressed
    logic [w_sw - 1:0]   sw  = {1'b1, {(w_sw - 1){1'b0}}};     // Top switch is reset
    logic [w_led - 1:0]  led;
    logic [7:0]          hex_out [w_digit];
    wire  [w_gpio - 1:0] gpio;
    logic                sd  = 1'b0;

    logic [31:0]           stim_mem [max_steps];
    int                    n_steps       = 0;
    int                    timeout_limit = 2000;
    logic [w_sample - 1:0] held_sample   = '0;
    logic [w_sample - 1:0] step_sample;
    logic                  step_mute;
    logic                  step_hold;
    logic [w_sound - 1:0]  exp_sound;

    int errors      = 0;
    int n_checks    = 0;
    int cycle_count = 0;
    int rel_cycles  = 0;       // Cycles since reset release

    // Microphone model state
    logic [w_sample - 1:0] mic_word  = '0;
    logic [w_sample - 1:0] slot_word = '0;
    int                    stim_gen  = 0;
    int                    slot_gen  = 0;
    int                    done_gen  = 0;
    logic                  mic_sck_q = 1'b0;
    logic                  mic_ws_q  = 1'b0;
    logic [5:0]            slot_pos  = '0;
    logic [31:0]           rng       = 32'd64;

    // I2S output decoder state
    logic                 bclk_q       = 1'b0;
    logic                 lr_q         = 1'b0;
    logic [w_sound - 1:0] aud_shreg    = '0;
    logic [w_sound - 1:0] left_word    = '0;
    logic [w_sound - 1:0] right_word   = '0;
    int                   frames_done  = 0;
    logic                 mclk_q       = 1'b0;
    int                   mclk_toggles = 0;

    board_specific_top
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz ),
        .w_key       ( w_key       ),
        .w_sw        ( w_sw        ),
        .w_led       ( w_led       ),
        .w_digit     ( w_digit     ),
        .w_gpio      ( w_gpio      )
    )
    dut0
    (
        .clk  ( clk        ),
        .key  ( key        ),
        .sw   ( sw         ),
        .led  ( led        ),
        .hex0 ( hex_out[0] ),
        .hex1 ( hex_out[1] ),
        .hex2 ( hex_out[2] ),
        .hex3 ( hex_out[3] ),
        .hex4 ( hex_out[4] ),
        .hex5 ( hex_out[5] ),
        .gpio ( gpio       )
    );

    assign gpio[5] = sd;    // Mic data line

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Board HEX code with segment a in bit 0 and segments lit low
    function automatic logic [7:0] expected_hex(input logic [w_sample - 1:0] sample, input int n);
        logic [7:0] seg;
        logic [7:0] rev;
        seg = hex_to_segments(sample[n * 4 +: 4]);
        for (int b = 0; b < 8; b++)
            rev[b] = seg[7 - b];
        return ~rev;
    endfunction

    //------------------------------------------------
    // Microphone model drives data on falling sck

    always @(posedge clk)
    begin
        logic [5:0]  pos;
        logic [31:0] rng_next;
        if (sw[w_sw - 1])
        begin
            mic_sck_q <= 1'b0;
            mic_ws_q  <= 1'b0;
            slot_pos  <= '0;
        end
        else
        begin
            mic_sck_q <= gpio[4];
            mic_ws_q  <= gpio[2];
            if (mic_sck_q && !gpio[4])
            begin
                pos      = (gpio[2] != mic_ws_q) ? 6'd0 : slot_pos + 1'b1;
                rng_next = xorshift32(rng);
                slot_pos <= pos;
                if (!gpio[2] && pos >= 1 && pos <= w_sample)
                    sd <= slot_word[w_sample - pos];    // MSB after the delay bit
                else
                begin
                    sd  <= rng_next[0];
                    rng <= rng_next;
                end
                if (!gpio[2] && pos == 6'd0)
                begin
                    slot_word <= mic_word;
                    slot_gen  <= stim_gen;
                end
                if (!gpio[2] && pos == 6'(w_sample + 1))
                    done_gen <= slot_gen;               // LSB already sampled
            end
        end
    end

    //------------------------------------------------
    // Audio decoder sampling on rising bclk

    always @(posedge clk)
    begin
        logic [w_sound - 1:0] shifted;
        if (sw[w_sw - 1])
        begin
            bclk_q    <= 1'b0;
            lr_q      <= 1'b0;
            aud_shreg <= '0;
        end
        else
        begin
            bclk_q <= gpio[31];
            if (!bclk_q && gpio[31])
            begin
                shifted   = {aud_shreg[w_sound - 2:0], gpio[29]};
                aud_shreg <= shifted;
                lr_q      <= gpio[27];
                // Bit right after an lrclk edge is the LSB of the word before
                if (gpio[27] && !lr_q)
                    left_word <= shifted;
                else if (!gpio[27] && lr_q)
                begin
                    right_word  <= shifted;
                    frames_done <= frames_done + 1;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (!sw[w_sw - 1])
            rel_cycles <= rel_cycles + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("timeout: run stopped after %0d clk cycles", cycle_count);
            $display("checks: %0d, errors: %0d", n_checks, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //------------------------------------------------

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_display(input string name, input logic [w_sample - 1:0] sample);
        for (int n = 0; n < w_digit; n++)
            check($sformatf("%s_hex%0d", name, n), 32'(expected_hex(sample, n)),
                  32'(hex_out[n]));
    endtask

    task automatic check_led(input string name);
        int               n;
        logic [w_led - 1:0] exp_led;
        logic [w_led - 1:0] prev_led;
        n        = rel_cycles / slow_period;
        exp_led  = w_led'(n);
        prev_led = exp_led - 1'b1;
        if (n > 0 && led == prev_led)
            exp_led = prev_led;     // Strobe may still be in flight
        check(name, 32'(exp_led), 32'(led));
    endtask

    // First frame that starts after the call carries the current sound
    task automatic check_audio(input string name, input logic [w_sound - 1:0] expected);
        int f0;
        f0 = frames_done;
        while (frames_done < f0 + 2)
            @(posedge clk);
        @(negedge clk);
        check({name, "_left"}, 32'(expected), 32'(left_word));
        check({name, "_right"}, 32'(expected), 32'(right_word));
    endtask

    //------------------------------------------------
    // Main sequence

    initial
    begin
        $readmemh("sim/board_stim.mem", stim_mem);
        while (n_steps < max_steps && stim_mem[n_steps][7:0] != 8'hff)
            n_steps++;
        timeout_limit = n_steps * 3 * mic_frame_clk + 2000;
        if (n_steps == 0)
        begin
            errors++;
            $display("stimulus file holds no test steps");
        end

        repeat (2) @(posedge clk);
        sw[w_sw - 1] <= 1'b0;

        wait_cycles(20);
        @(negedge clk);
        for (int n = 0; n < w_digit; n++)
            check($sformatf("reset_hex%0d", n), 32'hff, 32'(hex_out[n]));
        check("reset_led", 32'h0, 32'(led));
        check("mic_lr", 32'h0, 32'(gpio[0]));     // Left channel select
        check("mic_gnd", 32'h0, 32'(gpio[1]));
        check("mic_vdd", 32'h1, 32'(gpio[3]));

        // Mclk half period is aud_mclk_div clk
        mclk_q = gpio[33];
        repeat (8 * aud_mclk_div)
        begin
            @(negedge clk);
            if (gpio[33] !== mclk_q)
                mclk_toggles++;
            mclk_q = gpio[33];
        end
        check("mclk_toggles", 32'd8, 32'(mclk_toggles));

        check_audio("reset_audio", '0);

        for (int i = 0; i < n_steps; i++)
        begin
            step_sample = stim_mem[i][31:8];
            step_mute   = stim_mem[i][4];
            step_hold   = stim_mem[i][0];
            if (!step_hold)
                held_sample = step_sample;
            exp_sound = step_mute ? '0 : held_sample[w_sample - 1 -: w_sound];

            @(posedge clk);
            mic_word <= step_sample;
            stim_gen <= stim_gen + 1;
            sw[0]    <= step_mute;
            key[0]   <= !step_hold;     // Pressed key reads low

            @(posedge clk);
            while (done_gen != stim_gen)
                @(posedge clk);
            wait_cycles(settle_clk);
            @(negedge clk);
            check_display($sformatf("step%0d", i), held_sample);
            check_led($sformatf("step%0d_led", i));
            check_audio($sformatf("step%0d_audio", i), exp_sound);
        end

        $display("checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
